/* hdl/basicOps.sv */
`timescale 1ns/1ps

module basicOps
(
	opBus.ops ops
);

	////////////////////////////////////////////////////////////////////////////
	// Saturation helpers
	////////////////////////////////////////////////////////////////////////////

	// A 17-bit result overflowed when its top two bits disagree
	function automatic lspPkg::word16 sat16(input logic [16:0] wide);
		lspPkg::word16 result;
		if (wide[16] != wide[15])
			result = wide[16] ? 16'h8000 : 16'h7fff;
		else
			result = wide[15:0];
		return result;
	endfunction

	// Same rule at 32 bits, clipping to the long extremes
	function automatic lspPkg::word32 sat32(input logic [32:0] wide);
		lspPkg::word32 result;
		if (wide[32] != wide[31])
			result = wide[32] ? 32'h8000_0000 : 32'h7fff_ffff;
		else
			result = wide[31:0];
		return result;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Operators
	////////////////////////////////////////////////////////////////////////////

	logic [16:0] addWide;
	logic [16:0] subWide;
	logic [32:0] lAddWide;
	logic [32:0] lSubWide;

	// Sign-extend by one bit so the carry shows overflow
	assign addWide = {ops.addA[15], ops.addA} + {ops.addB[15], ops.addB};
	assign subWide = {ops.subA[15], ops.subA} - {ops.subB[15], ops.subB};
	assign lAddWide = {ops.lAddA[31], ops.lAddA} + {ops.lAddB[31], ops.lAddB};
	assign lSubWide = {ops.lSubA[31], ops.lSubA} - {ops.lSubB[31], ops.lSubB};

	assign ops.addSum = sat16(addWide);     // add()
	assign ops.subDiff = sat16(subWide);    // sub()
	assign ops.lAddSum = sat32(lAddWide);   // L_add()
	assign ops.lSubDiff = sat32(lSubWide);  // L_sub()

endmodule

/* hdl/lspMemory.sv */
`timescale 1ns/1ps

module lspMemory
(
	input logic clk,
	memPort.ram seq,
	input lspPkg::memAddr hostAddr,
	input lspPkg::word32 hostWriteData,
	input logic hostWriteEn,
	output lspPkg::word32 hostReadData
);

	localparam int memDepth = 2 ** lspPkg::memAddrWidth;

	lspPkg::word32 ram [memDepth];

	////////////////////////////////////////////////////////////////////////////
	// Two independent ports, both with one cycle of read latency
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (seq.writeEn)
			ram[seq.writeAddr] <= seq.writeData;
		if (hostWriteEn)
			ram[hostAddr] <= hostWriteData;   // Host stays off while busy

		// Nonblocking reads give old data on a same-address write
		seq.readData <= ram[seq.readAddr];
		hostReadData <= ram[hostAddr];
	end

endmodule

/* hdl/lspPkg.sv */
package lspPkg;

	////////////////////////////////////////////////////////////////////////////
	// Word types
	////////////////////////////////////////////////////////////////////////////

	localparam int memAddrWidth = 12;

	typedef logic [15:0] word16;             // Q-format LSP value or operand
	typedef logic [31:0] word32;             // Memory word or long accumulator
	typedef logic [memAddrWidth-1:0] memAddr;

	// Sequencer states, in order of the C loop structure
	typedef enum logic [3:0]
	{
		idle,
		pass1Test, pass1LoadHigh, pass1LoadLow,
		pass1ReadHigh, pass1ReadLow, pass1WriteHigh, pass1WriteLow,
		clampLow,
		pass2Test, pass2LoadHigh, pass2LoadLow, pass2Compare, pass2Write, pass2Next,
		clampHigh
	} seqState;

	////////////////////////////////////////////////////////////////////////////
	// G.729 stability constants
	////////////////////////////////////////////////////////////////////////////

	localparam word16 lLimit = 16'd40;       // Floor for element 0
	localparam word16 mLimit = 16'd25681;    // Ceiling for the last element
	localparam word16 gap3 = 16'd321;        // Minimum neighbor spacing

endpackage

/* hdl/lspStability.sv */
`timescale 1ns/1ps

module lspStability
#(
	parameter int lpcOrder = 10,
	parameter int indexWidth = 4
)
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic [7:0] bufBase,
	input lspPkg::memAddr hostAddr,
	input lspPkg::word32 hostWriteData,
	input logic hostWriteEn,
	output lspPkg::word32 hostReadData,
	output logic busy,
	output logic done
);

	opBus opLink();
	memPort seqPort();

	lspStabilityFsm #(
		.lpcOrder(lpcOrder),
		.indexWidth(indexWidth)
	) sequencer (
		.clk(clk),
		.reset(reset),
		.start(start),
		.bufBase(bufBase),
		.ops(opLink.seq),
		.mem(seqPort.user),
		.busy(busy),
		.done(done)
	);

	basicOps operators (
		.ops(opLink.ops)
	);

	lspMemory scratch (
		.clk(clk),
		.seq(seqPort.ram),
		.hostAddr(hostAddr),
		.hostWriteData(hostWriteData),
		.hostWriteEn(hostWriteEn),
		.hostReadData(hostReadData)
	);

endmodule

/* hdl/lspStabilityFsm.sv */
`timescale 1ns/1ps

module lspStabilityFsm
#(
	parameter int lpcOrder = 10,
	parameter int indexWidth = 4
)
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic [7:0] bufBase,
	opBus.seq ops,
	memPort.user mem,
	output logic busy,
	output logic done
);

	localparam logic [indexWidth-1:0] lastIndex = indexWidth'(lpcOrder - 1);

	lspPkg::seqState state, stateNext;
	logic [indexWidth-1:0] j, jNext;
	lspPkg::word16 swapHold, swapHoldNext;   // tmp of the C swap
	lspPkg::word32 accHigh, accHighNext;     // L_acc, later L_diff
	lspPkg::word32 accLow, accLowNext;       // L_accb

	lspPkg::word16 jWord;
	lspPkg::word32 readSext;
	logic [indexWidth-1:0] jPlusOne;

	// Buffer base in the upper bits, element index in the lower ones
	function automatic lspPkg::memAddr addrOf(input logic [indexWidth-1:0] idx);
		return {bufBase[lspPkg::memAddrWidth-indexWidth-1:0], idx};
	endfunction

	assign jWord = {{(16-indexWidth){1'b0}}, j};
	assign readSext = {{16{mem.readData[15]}}, mem.readData[15:0]};   // L_deposit_l
	assign jPlusOne = ops.addSum[indexWidth-1:0];

	assign busy = (state != lspPkg::idle);
	assign done = (state == lspPkg::clampHigh);

	////////////////////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= lspPkg::idle;
			j <= '0;
		end
		else
		begin
			state <= stateNext;
			j <= jNext;
		end
	end

	// Datapath holding registers
	always_ff @(posedge clk)
	begin
		swapHold <= swapHoldNext;
		accHigh <= accHighNext;
		accLow <= accLowNext;
	end

	////////////////////////////////////////////////////////////////////////////
	// Next state and datapath control
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		stateNext = state;
		jNext = j;
		swapHoldNext = swapHold;
		accHighNext = accHigh;
		accLowNext = accLow;

		// Adder defaults to j + 1 for index stepping
		ops.addA = jWord;
		ops.addB = 16'd1;
		ops.subA = '0;
		ops.subB = '0;
		ops.lAddA = '0;
		ops.lAddB = '0;
		ops.lSubA = '0;
		ops.lSubB = '0;

		mem.readAddr = '0;
		mem.writeAddr = '0;
		mem.writeData = '0;
		mem.writeEn = 1'b0;

		case (state)
			lspPkg::idle:
			begin
				jNext = '0;
				if (start)
					stateNext = lspPkg::pass1Test;
			end

			// Bubble pass over neighbor pairs
			lspPkg::pass1Test:
			begin
				if (j >= lastIndex)
				begin
					mem.readAddr = addrOf('0);      // buf[0] for the low clamp
					stateNext = lspPkg::clampLow;
				end
				else
				begin
					mem.readAddr = addrOf(jPlusOne);
					stateNext = lspPkg::pass1LoadHigh;
				end
			end

			lspPkg::pass1LoadHigh:
			begin
				accHighNext = readSext;
				mem.readAddr = addrOf(j);
				stateNext = lspPkg::pass1LoadLow;
			end

			lspPkg::pass1LoadLow:
			begin
				ops.lSubA = accHigh;
				ops.lSubB = readSext;
				if (ops.lSubDiff[31])                // Out of order
					stateNext = lspPkg::pass1ReadHigh;
				else
				begin
					jNext = jPlusOne;
					stateNext = lspPkg::pass1Test;
				end
			end

			lspPkg::pass1ReadHigh:
			begin
				mem.readAddr = addrOf(jPlusOne);
				stateNext = lspPkg::pass1ReadLow;
			end

			lspPkg::pass1ReadLow:
			begin
				swapHoldNext = mem.readData[15:0];  // tmp = buf[j+1]
				mem.readAddr = addrOf(j);
				stateNext = lspPkg::pass1WriteHigh;
			end

			lspPkg::pass1WriteHigh:
			begin
				mem.writeAddr = addrOf(jPlusOne);   // buf[j+1] = buf[j]
				mem.writeData = {16'd0, mem.readData[15:0]};
				mem.writeEn = 1'b1;
				stateNext = lspPkg::pass1WriteLow;
			end

			lspPkg::pass1WriteLow:
			begin
				mem.writeAddr = addrOf(j);          // buf[j] = tmp
				mem.writeData = {16'd0, swapHold};
				mem.writeEn = 1'b1;
				jNext = jPlusOne;
				stateNext = lspPkg::pass1Test;
			end

			lspPkg::clampLow:
			begin
				ops.subA = mem.readData[15:0];
				ops.subB = lspPkg::lLimit;
				if (ops.subDiff[15])
				begin
					mem.writeAddr = addrOf('0);
					mem.writeData = {16'd0, lspPkg::lLimit};
					mem.writeEn = 1'b1;
				end
				jNext = '0;
				stateNext = lspPkg::pass2Test;
			end

			// Spacing pass
			lspPkg::pass2Test:
			begin
				if (j >= lastIndex)
				begin
					mem.readAddr = addrOf(lastIndex);
					stateNext = lspPkg::clampHigh;
				end
				else
				begin
					mem.readAddr = addrOf(jPlusOne);
					stateNext = lspPkg::pass2LoadHigh;
				end
			end

			lspPkg::pass2LoadHigh:
			begin
				accHighNext = readSext;
				mem.readAddr = addrOf(j);
				stateNext = lspPkg::pass2LoadLow;
			end

			lspPkg::pass2LoadLow:
			begin
				accLowNext = readSext;
				ops.lSubA = accHigh;
				ops.lSubB = readSext;
				accHighNext = ops.lSubDiff;         // Now holds L_diff
				stateNext = lspPkg::pass2Compare;
			end

			lspPkg::pass2Compare:
			begin
				ops.lSubA = accHigh;
				ops.lSubB = {{16{lspPkg::gap3[15]}}, lspPkg::gap3};
				if (ops.lSubDiff[31])
					stateNext = lspPkg::pass2Write;
				else
				begin
					jNext = jPlusOne;
					stateNext = lspPkg::pass2Test;
				end
			end

			// Adder busy with the value, so L_add forms j + 1
			lspPkg::pass2Write:
			begin
				ops.addA = accLow[15:0];
				ops.addB = lspPkg::gap3;
				ops.lAddA = {16'd0, jWord};
				ops.lAddB = 32'd1;
				mem.writeAddr = addrOf(ops.lAddSum[indexWidth-1:0]);
				mem.writeData = {16'd0, ops.addSum};
				mem.writeEn = 1'b1;
				stateNext = lspPkg::pass2Next;
			end

			lspPkg::pass2Next:
			begin
				jNext = jPlusOne;
				stateNext = lspPkg::pass2Test;
			end

			lspPkg::clampHigh:
			begin
				ops.subA = mem.readData[15:0];
				ops.subB = lspPkg::mLimit;
				if (!ops.subDiff[15] && (ops.subDiff != '0))   // Strictly above
				begin
					mem.writeAddr = addrOf(lastIndex);
					mem.writeData = {16'd0, lspPkg::mLimit};
					mem.writeEn = 1'b1;
				end
				stateNext = lspPkg::idle;
			end

			default:
				stateNext = lspPkg::idle;
		endcase
	end

endmodule

/* hdl/memPort.sv */
`timescale 1ns/1ps

// One synchronous read/write port of the scratch RAM
interface memPort;

	lspPkg::memAddr readAddr;
	lspPkg::memAddr writeAddr;
	lspPkg::word32 writeData;
	lspPkg::word32 readData;     // Word at readAddr of the previous cycle
	logic writeEn;

	modport user
	(
		output readAddr, writeAddr, writeData, writeEn,
		input readData
	);

	modport ram
	(
		input readAddr, writeAddr, writeData, writeEn,
		output readData
	);

endinterface

/* hdl/opBus.sv */
`timescale 1ns/1ps

// Operand and result lines to the shared basic operator unit
interface opBus;

	lspPkg::word16 addA;
	lspPkg::word16 addB;
	lspPkg::word16 addSum;
	lspPkg::word16 subA;
	lspPkg::word16 subB;
	lspPkg::word16 subDiff;
	lspPkg::word32 lAddA;
	lspPkg::word32 lAddB;
	lspPkg::word32 lAddSum;
	lspPkg::word32 lSubA;
	lspPkg::word32 lSubB;
	lspPkg::word32 lSubDiff;

	modport seq
	(
		output addA, addB, subA, subB, lAddA, lAddB, lSubA, lSubB,
		input addSum, subDiff, lAddSum, lSubDiff
	);

	modport ops
	(
		input addA, addB, subA, subB, lAddA, lAddB, lSubA, lSubB,
		output addSum, subDiff, lAddSum, lSubDiff
	);

endinterface

/* lspStability.f */
hdl/lspPkg.sv
hdl/opBus.sv
hdl/memPort.sv
hdl/basicOps.sv
hdl/lspMemory.sv
hdl/lspStabilityFsm.sv
hdl/lspStability.sv
test/lspStabilityTb.sv

/* run.sh */
#!/bin/sh
# Build and run the LSP stability testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module lspStabilityTb \
	-f lspStability.f \
	-o lspStabilitySim

./obj_dir/lspStabilitySim | tee sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

/* test/lspStabilityTb.sv */
`timescale 1ns/1ps

module lspStabilityTb;

	localparam int lpcOrder = 10;
	localparam int bufWords = 16;
	localparam int resetCycles = 2;
	localparam int doneLimit = 200;               // Cycles allowed per test
	localparam int loadCycles = bufWords + 3;
	localparam int readCycles = 2 * bufWords + 2;
	localparam int randomTests = 50;
	localparam int testCount = 5 + randomTests;
	localparam int timeoutCycles =
		testCount * (doneLimit + loadCycles + readCycles) + resetCycles + 20;

	// G.729 stability bounds
	localparam int lowLimit = 40;
	localparam int highLimit = 25681;
	localparam int minGap = 321;

	typedef int lspArray [lpcOrder];

	logic clk = 1'b0;
	logic reset;
	logic start;
	logic [7:0] bufBase;
	lspPkg::memAddr hostAddr;
	lspPkg::word32 hostWriteData;
	logic hostWriteEn;
	lspPkg::word32 hostReadData;
	logic busy;
	logic done;

	logic [31:0] lfsrState = 32'h3d7a456a;
	int testNumber = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int checkErrors = 0;
	bit stalled = 1'b0;                            // Set when done never came

	lspStability #(
		.lpcOrder(lpcOrder),
		.indexWidth(4)
	) dut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.bufBase(bufBase),
		.hostAddr(hostAddr),
		.hostWriteData(hostWriteData),
		.hostWriteEn(hostWriteEn),
		.hostReadData(hostReadData),
		.busy(busy),
		.done(done)
	);

	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Reference model and stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic int saturatingAdd(input int a, input int b);
		int sum;
		sum = a + b;
		if (sum > 32767)
			sum = 32767;
		else if (sum < -32768)
			sum = -32768;
		return sum;
	endfunction

	// Single bubble pass, low clamp, spacing pass, high clamp
	function automatic void lspStabilityModel(input lspArray inVals, output lspArray outVals);
		lspArray v;
		int tmp;
		v = inVals;
		for (int j = 0; j < lpcOrder - 1; j++)
		begin
			if (v[j + 1] - v[j] < 0)
			begin
				tmp = v[j + 1];
				v[j + 1] = v[j];
				v[j] = tmp;
			end
		end
		if (v[0] < lowLimit)
			v[0] = lowLimit;
		for (int j = 0; j < lpcOrder - 1; j++)
			if (v[j + 1] - v[j] < minGap)
				v[j + 1] = saturatingAdd(v[j], minGap);
		if (v[lpcOrder - 1] > highLimit)
			v[lpcOrder - 1] = highLimit;
		outVals = v;
	endfunction

	// Guard pattern spread over the whole address
	function automatic lspPkg::word32 guardWord(input lspPkg::memAddr addr);
		return {8'hc3, addr, 4'h5, ~addr[7:0]};
	endfunction

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic takeBits(input int count, output int bits);
		bits = 0;
		for (int i = 0; i < count; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			bits = (bits << 1) | int'(lfsrState[0]);
		end
	endtask

	task automatic randomBuffer(output lspArray vals);
		int magnitude;
		int sign;
		for (int i = 0; i < lpcOrder; i++)
		begin
			takeBits(15, magnitude);
			takeBits(1, sign);
			vals[i] = (sign != 0) ? -magnitude : magnitude;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Bus tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic loadBuffer(input logic [7:0] base, input lspArray vals);
		for (int i = 0; i < bufWords; i++)
		begin
			@(posedge clk);
			hostAddr <= {base, 4'(i)};
			if (i < lpcOrder)
				hostWriteData <= {16'd0, 16'(vals[i])};
			else
				hostWriteData <= guardWord({base, 4'(i)});
			hostWriteEn <= 1'b1;
		end
		@(posedge clk);
		hostWriteEn <= 1'b0;
	endtask

	task automatic readWord(input lspPkg::memAddr addr, output lspPkg::word32 data);
		@(posedge clk);
		hostAddr <= addr;
		@(posedge clk);                          // RAM registers the read
		@(negedge clk);
		data = hostReadData;
	endtask

	task automatic checkWord(input int idx, input lspPkg::word32 expected,
		input lspPkg::word32 actual);
		assert (actual === expected)
		else
		begin
			$display("Mismatch at %0t ns: word %0d expected %h, got %h",
				$time, idx, expected, actual);
			checkErrors++;
		end
	endtask

	task automatic runTest(input string name, input logic [7:0] base, input lspArray vals);
		lspArray expected;
		lspPkg::word32 actual;
		lspPkg::word32 expectedWord;
		int errorsBefore;
		int cycles;
		bit seenDone;
		if (stalled)
			return;
		testNumber++;
		errorsBefore = checkErrors;
		lspStabilityModel(vals, expected);
		loadBuffer(base, vals);

		@(posedge clk);
		bufBase <= base;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;

		cycles = 0;
		seenDone = 1'b0;
		while (!seenDone && cycles < doneLimit)
		begin
			@(negedge clk);
			seenDone = done;
			cycles++;
		end
		if (!seenDone)
		begin
			$display("Test %0d (%s): done never came within %0d cycles",
				testNumber, name, doneLimit);
			testsFailed++;
			stalled = 1'b1;
			return;
		end
		assert (busy)
		else
		begin
			$display("Test %0d (%s): busy was low while done was high", testNumber, name);
			checkErrors++;
		end
		@(negedge clk);
		assert (!busy && !done)
		else
		begin
			$display("Test %0d (%s): busy or done still high the cycle after done",
				testNumber, name);
			checkErrors++;
		end

		for (int i = 0; i < bufWords; i++)
		begin
			readWord({base, 4'(i)}, actual);
			if (i < lpcOrder)
				expectedWord = {16'd0, 16'(expected[i])};
			else
				expectedWord = guardWord({base, 4'(i)});
			checkWord(i, expectedWord, actual);
		end

		if (checkErrors == errorsBefore)
		begin
			testsPassed++;
			$display("Test %0d (%s): ok", testNumber, name);
		end
		else
		begin
			testsFailed++;
			$display("Test %0d (%s): failed", testNumber, name);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		lspArray vals;
		reset <= 1'b1;
		start <= 1'b0;
		bufBase <= '0;
		hostAddr <= '0;
		hostWriteData <= '0;
		hostWriteEn <= 1'b0;
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;

		vals = '{100, 2000, 4500, 7000, 9500, 12000, 14500, 17000, 19500, 22000};
		runTest("ascending", 8'h21, vals);
		vals = '{1000, 3000, 2000, 5000, 9000, 8000, 7000, 6000, 20000, 24000};
		runTest("swaps", 8'h21, vals);
		vals = '{-500, 1000, 3000, 5000, 7000, 9000, 11000, 13000, 15000, 17000};
		runTest("low clamp", 8'h4e, vals);
		vals = '{2000, 2100, 2200, 2300, 10000, 10100, 32000, 32500, 32700, 32767};
		runTest("spacing", 8'h4e, vals);   // Top pairs clip at 32767
		vals = '{500, 3000, 6000, 9000, 12000, 15000, 18000, 21000, 24000, 30000};
		runTest("high clamp", 8'h21, vals);

		for (int t = 0; t < randomTests; t++)
		begin
			randomBuffer(vals);
			runTest("random", (t % 2 == 0) ? 8'h5c : 8'hb3, vals);
		end

		$display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
		if (testsFailed == 0 && !stalled)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		repeat (timeoutCycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
		$display(">>> FAIL");
		$finish;
	end

endmodule
